// ==== design/dsp_ctrl_pkg.sv ====
`default_nettype none

package dsp_ctrl_pkg;

	// ========================================
	// instruction classes
	// ========================================

	typedef enum logic [2:0] {
		CLS_NOP = 3'd0,
		CLS_ALU = 3'd1,
		CLS_MUL = 3'd2,
		CLS_DIV = 3'd3,
		CLS_FC = 3'd4,
		CLS_MEM = 3'd5,
		CLS_FPU = 3'd6
	} op_class_e;

	// functional unit code carried in each station entry
	typedef logic [3:0] fu_code_t;

	// dispatch slot numbers
	localparam int U_ALU0 = 0;
	localparam int U_MDIV = 1;
	localparam int U_FC = 2;
	localparam int U_MEM = 3;
	localparam int U_FPU = 4;
	localparam int U_ALU1 = 5;

	// unit codes seen by the reservation stations
	localparam fu_code_t FU_ALU0 = 4'd0;
	localparam fu_code_t FU_ALU1 = 4'd1;
	localparam fu_code_t FU_MUL = 4'd2;
	localparam fu_code_t FU_DIV = 4'd3;
	localparam fu_code_t FU_FPU = 4'd4;
	localparam fu_code_t FU_FC = 4'd7;
	localparam fu_code_t FU_MEM = 4'd8;

	// preferred dispatch slot for a class, alu ops start at alu0
	function automatic int cls_unit(input op_class_e cls);
		case (cls)
			CLS_MUL, CLS_DIV: cls_unit = U_MDIV;
			CLS_FC: cls_unit = U_FC;
			CLS_MEM: cls_unit = U_MEM;
			CLS_FPU: cls_unit = U_FPU;
			default: cls_unit = U_ALU0;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== design/dsp_defs.svh ====
`ifndef DSP_DEFS_SVH
`define DSP_DEFS_SVH

// ========================================
// dispatch stage geometry
// ========================================

// instructions delivered per rename group
`define DSP_GROUP_W 4

// dispatch slots, one per functional unit port
`define DSP_UNITS 6

// ========================================
// field widths
// ========================================

`define DSP_ROB_W 8
`define DSP_PREG_W 9
`define DSP_UOP_W 16
`define DSP_IP_W 32

// micro-op substituted for stomped or predicated-off instructions
`define DSP_OP_NOP 16'h00FF

// byte distance between neighbouring slots of a group
`define DSP_INSN_BYTES 4

`endif

// ==== design/dsp_group_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_group_reg
	import dsp_types_pkg::*, dsp_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ren_v_i,
	input ip_t ren_ip_i,
	input rob_ndx_t tail_i,
	input logic [`DSP_GROUP_W-1:0] ren_slot_v_i,
	input op_class_e [`DSP_GROUP_W-1:0] ren_cls_i,
	input logic [`DSP_GROUP_W-1:0] ren_alu0_i,
	input logic [`DSP_GROUP_W-1:0] ren_pred_i,
	input uop_t [`DSP_GROUP_W-1:0] ren_uop_i,
	input preg_t [`DSP_GROUP_W-1:0] ren_psa_i,
	input preg_t [`DSP_GROUP_W-1:0] ren_psb_i,
	input preg_t [`DSP_GROUP_W-1:0] ren_pd_i,
	input logic [`DSP_GROUP_W-1:0] ren_arga_v_i,
	input logic [`DSP_GROUP_W-1:0] ren_argb_v_i,
	input logic stall_dsp_i,
	output logic g_v_o,
	output ip_t g_ip_o,
	output rob_ndx_t g_tail_o,
	output logic [`DSP_GROUP_W-1:0] g_slot_v_o,
	output op_class_e [`DSP_GROUP_W-1:0] g_cls_o,
	output logic [`DSP_GROUP_W-1:0] g_alu0_o,
	output logic [`DSP_GROUP_W-1:0] g_pred_o,
	output uop_t [`DSP_GROUP_W-1:0] g_uop_o,
	output preg_t [`DSP_GROUP_W-1:0] g_psa_o,
	output preg_t [`DSP_GROUP_W-1:0] g_psb_o,
	output preg_t [`DSP_GROUP_W-1:0] g_pd_o,
	output logic [`DSP_GROUP_W-1:0] g_arga_v_o,
	output logic [`DSP_GROUP_W-1:0] g_argb_v_o
);

	logic load;

	// a new group is taken only once the current one has fully left
	assign load = ren_v_i & ~stall_dsp_i;

	// ========================================
	// group valid
	// ========================================

	// drops when rename sends nothing, held while stalled
	always_ff @(posedge clk) begin
		if (rst) begin
			g_v_o <= 1'b0;
		end else if (!stall_dsp_i) begin
			g_v_o <= ren_v_i;
		end
	end

	// ========================================
	// group payload
	// ========================================

	always_ff @(posedge clk) begin
		if (load) begin
			g_ip_o <= ren_ip_i;
			g_tail_o <= tail_i;
			g_slot_v_o <= ren_slot_v_i;
			g_cls_o <= ren_cls_i;
			g_alu0_o <= ren_alu0_i;
			g_pred_o <= ren_pred_i;
			g_uop_o <= ren_uop_i;
			g_psa_o <= ren_psa_i;
			g_psb_o <= ren_psb_i;
			g_pd_o <= ren_pd_i;
			g_arga_v_o <= ren_arga_v_i;
			g_argb_v_o <= ren_argb_v_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/dsp_rse_build.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_rse_build
	import dsp_types_pkg::*, dsp_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic g_v_i,
	input ip_t g_ip_i,
	input rob_ndx_t g_tail_i,
	input logic [`DSP_GROUP_W-1:0] g_slot_v_i,
	input op_class_e [`DSP_GROUP_W-1:0] g_cls_i,
	input logic [`DSP_GROUP_W-1:0] g_alu0_i,
	input logic [`DSP_GROUP_W-1:0] g_pred_i,
	input uop_t [`DSP_GROUP_W-1:0] g_uop_i,
	input preg_t [`DSP_GROUP_W-1:0] g_psa_i,
	input preg_t [`DSP_GROUP_W-1:0] g_psb_i,
	input preg_t [`DSP_GROUP_W-1:0] g_pd_i,
	input logic [`DSP_GROUP_W-1:0] g_arga_v_i,
	input logic [`DSP_GROUP_W-1:0] g_argb_v_i,
	input logic [`DSP_UNITS-1:0] sel_v_i,
	input gslot_t [`DSP_UNITS-1:0] sel_slot_i,
	input logic [`DSP_GROUP_W-1:0] stomp_i,
	output logic [`DSP_UNITS-1:0] rse_sel_o,
	output logic [`DSP_UNITS-1:0] rse_v_o,
	output fu_code_t [`DSP_UNITS-1:0] rse_fu_o,
	output rob_ndx_t [`DSP_UNITS-1:0] rse_rndx_o,
	output ip_t [`DSP_UNITS-1:0] rse_pc_o,
	output uop_t [`DSP_UNITS-1:0] rse_uop_o,
	output preg_t [`DSP_UNITS-1:0] rse_psa_o,
	output preg_t [`DSP_UNITS-1:0] rse_psb_o,
	output preg_t [`DSP_UNITS-1:0] rse_pd_o,
	output logic [`DSP_UNITS-1:0] rse_arga_v_o,
	output logic [`DSP_UNITS-1:0] rse_argb_v_o
);

	logic [`DSP_UNITS-1:0] sel_n, v_n, arga_n, argb_n;
	fu_code_t [`DSP_UNITS-1:0] fu_n;
	rob_ndx_t [`DSP_UNITS-1:0] rndx_n;
	ip_t [`DSP_UNITS-1:0] pc_n;
	uop_t [`DSP_UNITS-1:0] uop_n;
	preg_t [`DSP_UNITS-1:0] psa_n, psb_n, pd_n;

	// unit code follows the slot, the shared mul/div slot looks at the class
	function automatic fu_code_t unit_fu(input int u, input op_class_e cls, input logic alu0);
		case (u)
			U_MDIV: unit_fu = (cls == CLS_DIV) ? FU_DIV : FU_MUL;
			U_FC: unit_fu = FU_FC;
			U_MEM: unit_fu = FU_MEM;
			U_FPU: unit_fu = FU_FPU;
			U_ALU1: unit_fu = alu0 ? FU_ALU0 : FU_ALU1;
			default: unit_fu = FU_ALU0;
		endcase
	endfunction

	// ========================================
	// entry formation
	// ========================================

	always_comb begin
		gslot_t s;
		logic kill;
		s = '0;
		kill = 1'b0;
		sel_n = '0;
		v_n = '0;
		arga_n = '0;
		argb_n = '0;
		fu_n = '0;
		rndx_n = '0;
		pc_n = '0;
		uop_n = '0;
		psa_n = '0;
		psb_n = '0;
		pd_n = '0;
		for (int u = 0; u < `DSP_UNITS; u++) begin
			s = sel_slot_i[u];
			sel_n[u] = sel_v_i[u] & g_v_i & g_slot_v_i[s];
			if (sel_n[u]) begin
				// stomped or predicated off still goes out, as a ready nop
				kill = stomp_i[s] | ~g_pred_i[s];
				v_n[u] = ~stomp_i[s];
				fu_n[u] = unit_fu(u, g_cls_i[s], g_alu0_i[s]);
				rndx_n[u] = g_tail_i + rob_ndx_t'(s);
				pc_n[u] = g_ip_i + ip_t'(s) * ip_t'(`DSP_INSN_BYTES);
				uop_n[u] = kill ? uop_t'(`DSP_OP_NOP) : g_uop_i[s];
				psa_n[u] = g_psa_i[s];
				psb_n[u] = g_psb_i[s];
				pd_n[u] = g_pd_i[s];
				arga_n[u] = kill | g_arga_v_i[s];
				argb_n[u] = kill | g_argb_v_i[s];
			end
		end
	end

	// ========================================
	// output registers
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rse_sel_o <= '0;
			rse_v_o <= '0;
		end else begin
			rse_sel_o <= sel_n;
			rse_v_o <= v_n;
		end
	end

	// entry body, only meaningful where rse_sel_o is set
	always_ff @(posedge clk) begin
		rse_fu_o <= fu_n;
		rse_rndx_o <= rndx_n;
		rse_pc_o <= pc_n;
		rse_uop_o <= uop_n;
		rse_psa_o <= psa_n;
		rse_psb_o <= psb_n;
		rse_pd_o <= pd_n;
		rse_arga_v_o <= arga_n;
		rse_argb_v_o <= argb_n;
	end

endmodule

`default_nettype wire

// ==== design/dsp_steer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_steer
	import dsp_types_pkg::*, dsp_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic g_v_i,
	input logic [`DSP_GROUP_W-1:0] g_slot_v_i,
	input op_class_e [`DSP_GROUP_W-1:0] g_cls_i,
	input logic [`DSP_GROUP_W-1:0] g_alu0_i,
	input logic [`DSP_UNITS-1:0] busy_i,
	output logic [`DSP_UNITS-1:0] sel_v_o,
	output gslot_t [`DSP_UNITS-1:0] sel_slot_o,
	output logic stall_o
);

	// group slots that left in earlier cycles of a stalled group
	logic [`DSP_GROUP_W-1:0] done_q;
	// done_q plus whatever is placed this cycle
	logic [`DSP_GROUP_W-1:0] dispatched;
	logic [`DSP_UNITS-1:0] taken;
	gslot_t [`DSP_UNITS-1:0] sel_slot;
	logic stall;

	// ========================================
	// slot to unit steering
	// ========================================

	always_comb begin
		int u;
		logic placed;
		u = U_ALU0;
		placed = 1'b0;
		taken = '0;
		sel_slot = '0;
		dispatched = done_q;
		stall = 1'b0;
		// lowest group slot gets first pick of the units
		for (int s = 0; s < `DSP_GROUP_W; s++) begin
			if (g_v_i && g_slot_v_i[s] && g_cls_i[s] != CLS_NOP && !done_q[s]) begin
				u = cls_unit(g_cls_i[s]);
				placed = 1'b0;
				if (!taken[u] && !busy_i[u]) begin
					taken[u] = 1'b1;
					sel_slot[u] = gslot_t'(s);
					placed = 1'b1;
				end else if (g_cls_i[s] == CLS_ALU && !g_alu0_i[s] &&
						!taken[U_ALU1] && !busy_i[U_ALU1]) begin
					// second alu takes ops that are not tied to alu0
					taken[U_ALU1] = 1'b1;
					sel_slot[U_ALU1] = gslot_t'(s);
					placed = 1'b1;
				end
				if (placed) begin
					dispatched[s] = 1'b1;
				end else begin
					// unit in use or busy, retry next cycle
					stall = 1'b1;
				end
			end
		end
	end

	assign sel_v_o = taken;
	assign sel_slot_o = sel_slot;
	assign stall_o = stall;

	// ========================================
	// partial dispatch tracking
	// ========================================

	// the mask only lives while the same group is held
	always_ff @(posedge clk) begin
		if (rst) begin
			done_q <= '0;
		end else if (stall) begin
			done_q <= dispatched;
		end else begin
			done_q <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/dsp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dsp_defs.svh"

module dsp_top
	import dsp_types_pkg::*, dsp_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic ren_v_i,
	input ip_t ren_ip_i,
	input rob_ndx_t tail_i,
	input logic [`DSP_GROUP_W-1:0] ren_slot_v_i,
	input op_class_e [`DSP_GROUP_W-1:0] ren_cls_i,
	input logic [`DSP_GROUP_W-1:0] ren_alu0_i,
	input logic [`DSP_GROUP_W-1:0] ren_pred_i,
	input uop_t [`DSP_GROUP_W-1:0] ren_uop_i,
	input preg_t [`DSP_GROUP_W-1:0] ren_psa_i,
	input preg_t [`DSP_GROUP_W-1:0] ren_psb_i,
	input preg_t [`DSP_GROUP_W-1:0] ren_pd_i,
	input logic [`DSP_GROUP_W-1:0] ren_arga_v_i,
	input logic [`DSP_GROUP_W-1:0] ren_argb_v_i,
	input logic [`DSP_UNITS-1:0] busy_i,
	input logic [`DSP_GROUP_W-1:0] stomp_i,
	output logic stall_o,
	output logic [`DSP_UNITS-1:0] rse_sel_o,
	output logic [`DSP_UNITS-1:0] rse_v_o,
	output fu_code_t [`DSP_UNITS-1:0] rse_fu_o,
	output rob_ndx_t [`DSP_UNITS-1:0] rse_rndx_o,
	output ip_t [`DSP_UNITS-1:0] rse_pc_o,
	output uop_t [`DSP_UNITS-1:0] rse_uop_o,
	output preg_t [`DSP_UNITS-1:0] rse_psa_o,
	output preg_t [`DSP_UNITS-1:0] rse_psb_o,
	output preg_t [`DSP_UNITS-1:0] rse_pd_o,
	output logic [`DSP_UNITS-1:0] rse_arga_v_o,
	output logic [`DSP_UNITS-1:0] rse_argb_v_o
);

	// latched group
	logic g_v;
	ip_t g_ip;
	rob_ndx_t g_tail;
	logic [`DSP_GROUP_W-1:0] g_slot_v, g_alu0, g_pred, g_arga_v, g_argb_v;
	op_class_e [`DSP_GROUP_W-1:0] g_cls;
	uop_t [`DSP_GROUP_W-1:0] g_uop;
	preg_t [`DSP_GROUP_W-1:0] g_psa, g_psb, g_pd;

	// steering result
	logic [`DSP_UNITS-1:0] sel_v;
	gslot_t [`DSP_UNITS-1:0] sel_slot;
	logic stall_dsp;

	// rename sees the stall in the same cycle
	assign stall_o = stall_dsp;

	// ========================================
	// input side
	// ========================================

	dsp_group_reg u_grp (
		.clk(clk), .rst(rst),
		.ren_v_i(ren_v_i), .ren_ip_i(ren_ip_i), .tail_i(tail_i),
		.ren_slot_v_i(ren_slot_v_i), .ren_cls_i(ren_cls_i), .ren_alu0_i(ren_alu0_i),
		.ren_pred_i(ren_pred_i), .ren_uop_i(ren_uop_i),
		.ren_psa_i(ren_psa_i), .ren_psb_i(ren_psb_i), .ren_pd_i(ren_pd_i),
		.ren_arga_v_i(ren_arga_v_i), .ren_argb_v_i(ren_argb_v_i),
		.stall_dsp_i(stall_dsp),
		.g_v_o(g_v), .g_ip_o(g_ip), .g_tail_o(g_tail),
		.g_slot_v_o(g_slot_v), .g_cls_o(g_cls), .g_alu0_o(g_alu0), .g_pred_o(g_pred),
		.g_uop_o(g_uop), .g_psa_o(g_psa), .g_psb_o(g_psb), .g_pd_o(g_pd),
		.g_arga_v_o(g_arga_v), .g_argb_v_o(g_argb_v)
	);

	// ========================================
	// steering and entry build
	// ========================================

	dsp_steer u_steer (
		.clk(clk), .rst(rst),
		.g_v_i(g_v), .g_slot_v_i(g_slot_v), .g_cls_i(g_cls), .g_alu0_i(g_alu0),
		.busy_i(busy_i),
		.sel_v_o(sel_v), .sel_slot_o(sel_slot), .stall_o(stall_dsp)
	);

	dsp_rse_build u_rse (
		.clk(clk), .rst(rst),
		.g_v_i(g_v), .g_ip_i(g_ip), .g_tail_i(g_tail),
		.g_slot_v_i(g_slot_v), .g_cls_i(g_cls), .g_alu0_i(g_alu0), .g_pred_i(g_pred),
		.g_uop_i(g_uop), .g_psa_i(g_psa), .g_psb_i(g_psb), .g_pd_i(g_pd),
		.g_arga_v_i(g_arga_v), .g_argb_v_i(g_argb_v),
		.sel_v_i(sel_v), .sel_slot_i(sel_slot), .stomp_i(stomp_i),
		.rse_sel_o(rse_sel_o), .rse_v_o(rse_v_o), .rse_fu_o(rse_fu_o),
		.rse_rndx_o(rse_rndx_o), .rse_pc_o(rse_pc_o), .rse_uop_o(rse_uop_o),
		.rse_psa_o(rse_psa_o), .rse_psb_o(rse_psb_o), .rse_pd_o(rse_pd_o),
		.rse_arga_v_o(rse_arga_v_o), .rse_argb_v_o(rse_argb_v_o)
	);

endmodule

`default_nettype wire

// ==== design/dsp_types_pkg.sv ====
`default_nettype none

`include "dsp_defs.svh"

package dsp_types_pkg;

	// ========================================
	// payload types
	// ========================================

	// reorder buffer slot number
	typedef logic [`DSP_ROB_W-1:0] rob_ndx_t;

	// renamed physical register
	typedef logic [`DSP_PREG_W-1:0] preg_t;

	// micro-op as delivered by rename
	typedef logic [`DSP_UOP_W-1:0] uop_t;

	// instruction address
	typedef logic [`DSP_IP_W-1:0] ip_t;

	// position of an instruction inside its group
	typedef logic [$clog2(`DSP_GROUP_W)-1:0] gslot_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the dispatch testbench with verilator
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module dispatch_tb \
	-Mdir obj_dir -o dispatch_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dispatch_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== verif/dispatch_tb_tasks.svh ====
`ifndef DISPATCH_TB_TASKS_SVH
`define DISPATCH_TB_TASKS_SVH

// ========================================
// reference model state
// ========================================

// group the model believes is latched
logic cur_v;
ip_t cur_ip;
rob_ndx_t cur_tail;
logic [`DSP_GROUP_W-1:0] cur_slot_v, cur_alu0, cur_pred, cur_arga, cur_argb;
op_class_e [`DSP_GROUP_W-1:0] cur_cls;
uop_t [`DSP_GROUP_W-1:0] cur_uop;
preg_t [`DSP_GROUP_W-1:0] cur_psa, cur_psb, cur_pd;
// slots gone in earlier cycles, and slots placed in this one
logic [`DSP_GROUP_W-1:0] done_m, newly;

// entries expected after the coming edge
logic exp_stall;
logic [`DSP_UNITS-1:0] exp_sel, exp_v, exp_arga, exp_argb;
fu_code_t [`DSP_UNITS-1:0] exp_fu;
rob_ndx_t [`DSP_UNITS-1:0] exp_rndx;
ip_t [`DSP_UNITS-1:0] exp_pc;
uop_t [`DSP_UNITS-1:0] exp_uop;
preg_t [`DSP_UNITS-1:0] exp_psa, exp_psb, exp_pd;
int stall_cycles;

task automatic clear_model();
	cur_v = 1'b0;
	done_m = '0;
	newly = '0;
	exp_stall = 1'b0;
	exp_sel = '0;
	exp_v = '0;
	stall_cycles = 0;
endtask

// entry for group slot s placed on unit slot u
task automatic fill_entry(input int u, input int s);
	logic kill;
	kill = stomp_i[s] | ~cur_pred[s];
	exp_sel[u] = 1'b1;
	exp_v[u] = ~stomp_i[s];
	case (u)
		U_MDIV: exp_fu[u] = (cur_cls[s] == CLS_DIV) ? FU_DIV : FU_MUL;
		U_FC: exp_fu[u] = FU_FC;
		U_MEM: exp_fu[u] = FU_MEM;
		U_FPU: exp_fu[u] = FU_FPU;
		U_ALU1: exp_fu[u] = FU_ALU1;
		default: exp_fu[u] = FU_ALU0;
	endcase
	exp_rndx[u] = cur_tail + rob_ndx_t'(s);
	exp_pc[u] = cur_ip + ip_t'(`DSP_INSN_BYTES * s);
	// killed ops leave as a nop with nothing to wait for
	exp_uop[u] = kill ? uop_t'(`DSP_OP_NOP) : cur_uop[s];
	exp_psa[u] = cur_psa[s];
	exp_psb[u] = cur_psb[s];
	exp_pd[u] = cur_pd[s];
	exp_arga[u] = kill | cur_arga[s];
	exp_argb[u] = kill | cur_argb[s];
endtask

// steering rule, lowest group slot picks first
task automatic predict_cycle();
	int unit;
	logic [`DSP_UNITS-1:0] used;
	used = '0;
	newly = '0;
	exp_stall = 1'b0;
	exp_sel = '0;
	exp_v = '0;
	for (int s = 0; s < `DSP_GROUP_W; s++) begin
		if (cur_v && cur_slot_v[s] && cur_cls[s] != CLS_NOP && !done_m[s]) begin
			case (cur_cls[s])
				CLS_MUL, CLS_DIV: unit = U_MDIV;
				CLS_FC: unit = U_FC;
				CLS_MEM: unit = U_MEM;
				CLS_FPU: unit = U_FPU;
				default: unit = U_ALU0;
			endcase
			if (used[unit] || busy_i[unit]) begin
				// free alu ops may move over to alu1
				if (cur_cls[s] == CLS_ALU && !cur_alu0[s] && !used[U_ALU1] && !busy_i[U_ALU1])
					unit = U_ALU1;
				else
					unit = -1;
			end
			if (unit < 0) begin
				exp_stall = 1'b1;
			end else begin
				used[unit] = 1'b1;
				newly[s] = 1'b1;
				fill_entry(unit, s);
			end
		end
	end
endtask

task automatic check_entries();
	compare_field("rse_sel_o", 32'(rse_sel_o), 32'(exp_sel));
	compare_field("rse_v_o", 32'(rse_v_o), 32'(exp_v));
	for (int u = 0; u < `DSP_UNITS; u++) begin
		if (exp_sel[u]) begin
			compare_field($sformatf("rse_fu_o[%0d]", u), 32'(rse_fu_o[u]), 32'(exp_fu[u]));
			compare_field($sformatf("rse_rndx_o[%0d]", u), 32'(rse_rndx_o[u]), 32'(exp_rndx[u]));
			compare_field($sformatf("rse_pc_o[%0d]", u), rse_pc_o[u], exp_pc[u]);
			compare_field($sformatf("rse_uop_o[%0d]", u), 32'(rse_uop_o[u]), 32'(exp_uop[u]));
			compare_field($sformatf("rse_psa_o[%0d]", u), 32'(rse_psa_o[u]), 32'(exp_psa[u]));
			compare_field($sformatf("rse_psb_o[%0d]", u), 32'(rse_psb_o[u]), 32'(exp_psb[u]));
			compare_field($sformatf("rse_pd_o[%0d]", u), 32'(rse_pd_o[u]), 32'(exp_pd[u]));
			compare_field($sformatf("rse_arga_v_o[%0d]", u), 32'(rse_arga_v_o[u]),
				32'(exp_arga[u]));
			compare_field($sformatf("rse_argb_v_o[%0d]", u), 32'(rse_argb_v_o[u]),
				32'(exp_argb[u]));
		end
	end
endtask

// one clock: check last edge's entries mid cycle, predict, then step the model
task automatic cycle_step();
	logic take;
	@(negedge clk);
	check_entries();
	predict_cycle();
	compare_field("stall_o", 32'(stall_o), 32'(exp_stall));
	take = ren_v_i & ~exp_stall;
	// stall length as the dut reports it
	if (stall_o)
		stall_cycles++;
	if (exp_stall) begin
		done_m = done_m | newly;
	end else begin
		done_m = '0;
		cur_v = ren_v_i;
	end
	if (take) begin
		cur_ip = ren_ip_i;
		cur_tail = tail_i;
		cur_slot_v = ren_slot_v_i;
		cur_cls = ren_cls_i;
		cur_alu0 = ren_alu0_i;
		cur_pred = ren_pred_i;
		cur_uop = ren_uop_i;
		cur_psa = ren_psa_i;
		cur_psb = ren_psb_i;
		cur_pd = ren_pd_i;
		cur_arga = ren_arga_v_i;
		cur_argb = ren_argb_v_i;
	end
	@(posedge clk);
	// rename drops the strobe once its group is in
	if (take)
		ren_v_i <= 1'b0;
endtask

// ========================================
// stimulus
// ========================================

// called right after an edge, payload fields are random
task automatic strobe_group(input logic [3:0] vmask, input op_class_e c0, c1, c2, c3,
		input logic [3:0] alu0, input logic [3:0] pred);
	ren_v_i <= 1'b1;
	ren_ip_i <= ip_t'($random(seed));
	tail_i <= rob_ndx_t'($random(seed));
	ren_slot_v_i <= vmask;
	ren_cls_i[0] <= c0;
	ren_cls_i[1] <= c1;
	ren_cls_i[2] <= c2;
	ren_cls_i[3] <= c3;
	ren_alu0_i <= alu0;
	ren_pred_i <= pred;
	ren_arga_v_i <= 4'($random(seed));
	ren_argb_v_i <= 4'($random(seed));
	for (int s = 0; s < `DSP_GROUP_W; s++) begin
		ren_uop_i[s] <= uop_t'($random(seed));
		ren_psa_i[s] <= preg_t'($random(seed));
		ren_psb_i[s] <= preg_t'($random(seed));
		ren_pd_i[s] <= preg_t'($random(seed));
	end
endtask

task automatic expect_stalls(input int n);
	compare_field("stall_o cycles", 32'(stall_cycles), 32'(n));
	stall_cycles = 0;
endtask

// ========================================
// directed tests
// ========================================

task automatic idle_test();
	repeat (6) cycle_step();
	expect_stalls(0);
endtask

// four different units, all leave together
task automatic full_group_test();
	strobe_group(4'b1111, CLS_ALU, CLS_MUL, CLS_FC, CLS_MEM, 4'b0000, 4'b1111);
	repeat (4) cycle_step();
	expect_stalls(0);
endtask

// two divides and two loads need two cycles, the next group waits on stall
task automatic conflict_test();
	strobe_group(4'b1111, CLS_DIV, CLS_MEM, CLS_DIV, CLS_MEM, 4'b0000, 4'b1111);
	cycle_step();
	strobe_group(4'b0111, CLS_ALU, CLS_FC, CLS_FPU, CLS_NOP, 4'b0000, 4'b1111);
	repeat (5) cycle_step();
	expect_stalls(1);
endtask

// slot 1 is pinned to alu0, so slot 2 overtakes it on alu1
task automatic alu_pair_test();
	strobe_group(4'b0111, CLS_ALU, CLS_ALU, CLS_ALU, CLS_NOP, 4'b0010, 4'b1111);
	repeat (5) cycle_step();
	expect_stalls(1);
endtask

task automatic busy_unit_test();
	int hold;
	hold = 2 + int'({$random(seed)} % 5);
	busy_i[U_FPU] <= 1'b1;
	strobe_group(4'b0011, CLS_ALU, CLS_FPU, CLS_NOP, CLS_NOP, 4'b0000, 4'b1111);
	cycle_step();
	repeat (hold) cycle_step();
	busy_i[U_FPU] <= 1'b0;
	repeat (3) cycle_step();
	expect_stalls(hold);
endtask

// slot 0 stomped, slot 1 predicated off, neither has ready operands
task automatic kill_test();
	stomp_i <= 4'b0001;
	strobe_group(4'b1111, CLS_ALU, CLS_MEM, CLS_FC, CLS_MUL, 4'b0000, 4'b1101);
	ren_arga_v_i <= 4'b0000;
	ren_argb_v_i <= 4'b0000;
	repeat (2) cycle_step();
	stomp_i <= 4'b0000;
	repeat (2) cycle_step();
	expect_stalls(0);
endtask

`endif

// ==== verif/dispatch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dsp_defs.svh"

module dispatch_tb
	import dsp_types_pkg::*, dsp_ctrl_pkg::*;
;

	localparam int CLK_NS = 40;
	localparam int RST_CYCLES = 16;
	// longest test holds the fpu busy for up to six cycles
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 24;
	localparam int WATCHDOG_NS = (RST_CYCLES + TEST_COUNT * CYCLES_PER_TEST) * CLK_NS;

	logic clk;
	logic rst;

	// rename side stimulus
	logic ren_v_i;
	ip_t ren_ip_i;
	rob_ndx_t tail_i;
	logic [`DSP_GROUP_W-1:0] ren_slot_v_i, ren_alu0_i, ren_pred_i;
	logic [`DSP_GROUP_W-1:0] ren_arga_v_i, ren_argb_v_i;
	op_class_e [`DSP_GROUP_W-1:0] ren_cls_i;
	uop_t [`DSP_GROUP_W-1:0] ren_uop_i;
	preg_t [`DSP_GROUP_W-1:0] ren_psa_i, ren_psb_i, ren_pd_i;
	logic [`DSP_UNITS-1:0] busy_i;
	logic [`DSP_GROUP_W-1:0] stomp_i;

	// reservation station side
	logic stall_o;
	logic [`DSP_UNITS-1:0] rse_sel_o, rse_v_o, rse_arga_v_o, rse_argb_v_o;
	fu_code_t [`DSP_UNITS-1:0] rse_fu_o;
	rob_ndx_t [`DSP_UNITS-1:0] rse_rndx_o;
	ip_t [`DSP_UNITS-1:0] rse_pc_o;
	uop_t [`DSP_UNITS-1:0] rse_uop_o;
	preg_t [`DSP_UNITS-1:0] rse_psa_o, rse_psb_o, rse_pd_o;

	integer seed;

	dsp_top u_dut (.*);

	always #(CLK_NS / 2) clk = ~clk;

	// ========================================
	// checker
	// ========================================

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "dispatch output differs from the reference model");
		end
	endtask

	// reference model and the directed tests
	`include "dispatch_tb_tasks.svh"

	// ========================================
	// watchdog
	// ========================================

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout after %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$fatal(1, "simulation ran past its time limit");
	end

	// ========================================
	// test sequence
	// ========================================

	initial begin
		seed = 76;
		clk = 1'b0;
		rst = 1'b1;
		ren_v_i = 1'b0;
		ren_ip_i = '0;
		tail_i = '0;
		ren_slot_v_i = '0;
		ren_alu0_i = '0;
		ren_pred_i = '0;
		ren_arga_v_i = '0;
		ren_argb_v_i = '0;
		ren_uop_i = '0;
		ren_psa_i = '0;
		ren_psb_i = '0;
		ren_pd_i = '0;
		busy_i = '0;
		stomp_i = '0;
		for (int s = 0; s < `DSP_GROUP_W; s++) begin
			ren_cls_i[s] = CLS_NOP;
		end
		clear_model();
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		idle_test();
		full_group_test();
		conflict_test();
		alu_pair_test();
		busy_unit_test();
		kill_test();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
+incdir+verif
design/dsp_types_pkg.sv
design/dsp_ctrl_pkg.sv
design/dsp_group_reg.sv
design/dsp_steer.sv
design/dsp_rse_build.sv
design/dsp_top.sv
verif/dispatch_tb.sv
